//--- rtl/bp_settings.svh
////////////////////////////////////////
// Branch predictor front end settings
// PC step, instruction ROM size and the
// counter state after reset
////////////////////////////////////////

`ifndef BP_SETTINGS_SVH
`define BP_SETTINGS_SVH

// 16-bit instructions, byte addressed pc
`define BP_PC_STEP 16'd2

// ROM word address width, 256 words
`define BP_ROM_AW 8

// counter comes out of reset strong not taken
`define BP_CNT_RESET bp_pkg::snt

`endif

//--- rtl/bp_pkg.sv
////////////////////////////////////////
// Branch predictor front end types
// Opcodes, branch conditions, counter
// states and the instruction word views
////////////////////////////////////////

package bp_pkg;

    // only the opcodes the front end cares about
    typedef enum logic [3:0] {
        nop_op = 4'b0000,   // loaded into IF/ID by a flush
        b_op   = 4'b1100,   // B   ccc iiiiiiiii
        br_op  = 4'b1101    // BR  ccc ssss xxxxx
    } opcode_t;

    // condition codes, tested against Z V N
    typedef enum logic [2:0] {
        cc_ne = 3'b000,     // not equal, Z clear
        cc_eq = 3'b001,     // equal, Z set
        cc_gt = 3'b010,     // Z and N both clear
        cc_lt = 3'b011,     // N set
        cc_ge = 3'b100,     // Z set or N clear
        cc_le = 3'b101,     // Z set or N set
        cc_ov = 3'b110,     // V set
        cc_al = 3'b111      // unconditional
    } cond_t;

    // two-bit saturating counter
    typedef enum logic [1:0] {
        snt = 2'b00,
        wnt = 2'b01,
        wt  = 2'b10,
        st  = 2'b11
    } cnt_t;

    // one 16-bit word, read as B or as BR
    typedef union packed {
        struct packed {
            opcode_t    opcode;
            cond_t      cond;
            logic [8:0] offset;     // signed word offset
        } b;
        struct packed {
            opcode_t    opcode;
            cond_t      cond;
            logic [3:0] rs;         // register holding the target
            logic [4:0] pad;
        } br;
    } inst_u;

endpackage

//--- rtl/inst_rom.sv
////////////////////////////////////////
// Instruction memory
// Loaded through a clocked write port,
// read combinationally at the fetch pc
////////////////////////////////////////

`timescale 1ns/1ns
`include "bp_settings.svh"

module inst_rom (
    input  logic                  clk,
    input  logic                  rom_we,     // load strobe, only used during reset
    input  logic [`BP_ROM_AW-1:0] rom_addr,   // word address
    input  logic [15:0]           rom_wdata,
    input  logic [15:0]           pc,         // byte address from fetch
    output bp_pkg::inst_u         inst
);

    localparam int DEPTH = 2 ** `BP_ROM_AW;

    logic [15:0]           mem [0:DEPTH-1];   // contents come from the load port
    logic [`BP_ROM_AW-1:0] rd_addr;

    // word index is pc shifted right by one
    // upper pc bits drop off so fetch wraps around the array
    assign rd_addr = pc[`BP_ROM_AW:1];

    // load port
    always_ff @(posedge clk) begin
        if (rom_we) begin
            mem[rom_addr] <= rom_wdata;
        end
    end

    // read is asynchronous, word is ready in the fetch cycle
    assign inst = mem[rd_addr];

endmodule

//--- rtl/branch_predict_fsm.sv
////////////////////////////////////////
// Two-bit branch predictor
// One global saturating counter predicts
// B direction at fetch, a one-deep record
// follows the branch into ID and the
// resolved direction trains the counter
////////////////////////////////////////

`timescale 1ns/1ns
`include "bp_settings.svh"

module branch_predict_fsm (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic [15:0]   pc,           // fetch pc
    input  bp_pkg::inst_u inst,         // word at pc this cycle
    input  logic          id_is_b,      // B in IF/ID
    input  logic          id_is_br,     // BR in IF/ID
    input  logic          id_pred,      // prediction carried through IF/ID
    input  logic          taken,        // resolved direction from ID
    output logic [15:0]   predict_pc,   // next pc guess, combinational
    output logic          pred_taken,
    output logic          mispredict
);
    import bp_pkg::*;

    cnt_t        cnt;           // global counter
    cnt_t        cnt_nxt;
    logic        wait_b;        // record, a B is waiting for its result
    logic        wait_br;       // record, a BR is waiting
    logic        if_is_b;
    logic        if_is_br;
    logic        b_step;        // counter update enable
    logic [15:0] seq_pc;
    logic [15:0] b_off;         // offset in bytes, sign extended

    // fetch side decode
    assign if_is_b  = (inst.b.opcode == b_op);
    assign if_is_br = (inst.br.opcode == br_op);

    assign seq_pc = pc + `BP_PC_STEP;
    assign b_off  = {{6{inst.b.offset[8]}}, inst.b.offset, 1'b0};

    // upper counter bit is the direction, BR always guessed not taken
    assign pred_taken = if_is_b & cnt[1];
    assign predict_pc = pred_taken ? seq_pc + b_off : seq_pc;

    // the record and the IF/ID decode must both see the branch,
    // so a flushed slot can never raise a second mispredict
    assign mispredict = (wait_b & id_is_b & (id_pred ^ taken))
                      | (wait_br & id_is_br & taken);

    // train only on real B results and never while stalled
    assign b_step = ~stall & wait_b & id_is_b;

    // saturating step
    always_comb begin
        cnt_nxt = cnt;
        if (taken) begin
            case (cnt)
                snt:     cnt_nxt = wnt;
                wnt:     cnt_nxt = wt;
                default: cnt_nxt = st;       // wt and st both land on st
            endcase
        end else begin
            case (cnt)
                st:      cnt_nxt = wt;
                wt:      cnt_nxt = wnt;
                default: cnt_nxt = snt;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= `BP_CNT_RESET;
        end else if (b_step) begin
            cnt <= cnt_nxt;
        end
    end

    // one-deep waiting record, follows the word into ID
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_b  <= 1'b0;
            wait_br <= 1'b0;
        end else if (!stall) begin
            wait_b  <= if_is_b & ~mispredict;   // wrong path word is flushed
            wait_br <= if_is_br & ~mispredict;
        end
    end

endmodule

//--- rtl/branch_resolve.sv
////////////////////////////////////////
// Decode stage branch resolver
// Holds IF/ID with flush, tests the
// branch condition on Z V N and forms
// the correct continuation address
////////////////////////////////////////

`timescale 1ns/1ns
`include "bp_settings.svh"

module branch_resolve (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,
    input  logic          mispredict,   // flush the wrong path slot
    input  logic [15:0]   pc,
    input  bp_pkg::inst_u inst,
    input  logic          pred_taken,
    input  logic [2:0]    flags,        // {Z, V, N}
    input  logic [15:0]   br_data,      // value of the BR source register
    output logic          id_is_b,
    output logic          id_is_br,
    output logic          id_pred,
    output logic          taken,
    output logic [3:0]    br_rs,
    output logic [15:0]   redirect_pc
);
    import bp_pkg::*;

    logic [15:0] id_pc;
    inst_u       id_inst;
    logic        cond_true;
    logic        z;
    logic        v;
    logic        n;
    logic [15:0] seq_pc;        // fall through of the branch
    logic [15:0] b_target;

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_pc   <= 16'h0000;
            id_inst <= inst_u'({nop_op, 12'h000});
            id_pred <= 1'b0;
        end else if (!stall) begin
            id_pc <= pc;
            if (mispredict) begin
                id_inst <= inst_u'({nop_op, 12'h000});   // kill wrong path word
                id_pred <= 1'b0;
            end else begin
                id_inst <= inst;
                id_pred <= pred_taken;
            end
        end
    end

    assign id_is_b  = (id_inst.b.opcode == b_op);
    assign id_is_br = (id_inst.br.opcode == br_op);
    assign br_rs    = id_inst.br.rs;

    assign z = flags[2];
    assign v = flags[1];
    assign n = flags[0];

    // cond sits at the same bits in both views
    always_comb begin
        cond_true = 1'b0;
        case (id_inst.b.cond)
            cc_ne: cond_true = ~z;
            cc_eq: cond_true = z;
            cc_gt: cond_true = ~z & ~n;
            cc_lt: cond_true = n;
            cc_ge: cond_true = z | ~n;
            cc_le: cond_true = z | n;
            cc_ov: cond_true = v;
            cc_al: cond_true = 1'b1;
        endcase
    end

    // non branches never report taken
    assign taken = (id_is_b | id_is_br) & cond_true;

    assign seq_pc   = id_pc + `BP_PC_STEP;
    assign b_target = seq_pc + {{6{id_inst.b.offset[8]}}, id_inst.b.offset, 1'b0};

    assign redirect_pc = !taken   ? seq_pc  :
                         id_is_br ? br_data :
                                    b_target;

endmodule

//--- rtl/fetch_unit.sv
////////////////////////////////////////
// PC register and next pc select
// Mispredict redirect wins over the
// predicted pc, stall holds the pc
////////////////////////////////////////

`timescale 1ns/1ns

module fetch_unit (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,          // freeze fetch
    input  logic        mispredict,     // ID found a wrong guess
    input  logic [15:0] predict_pc,     // from the predictor, this cycle
    input  logic [15:0] redirect_pc,    // correct path from ID
    output logic [15:0] pc
);

    logic [15:0] pc_nxt;

    // redirect has priority, the fetched word is on the wrong path anyway
    assign pc_nxt = mispredict ? redirect_pc : predict_pc;

    // pc register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= 16'h0000;     // fetch starts at word 0
        end else if (!stall) begin
            pc <= pc_nxt;
        end
    end

endmodule

//--- rtl/bp_frontend.sv
////////////////////////////////////////
// Instruction fetch front end
// ROM, PC, two-bit predictor and the
// decode stage branch resolver
////////////////////////////////////////

`timescale 1ns/1ns
`include "bp_settings.svh"

module bp_frontend (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [2:0]            flags,        // {Z, V, N}
    input  logic [15:0]           br_data,      // BR target register value
    input  logic                  rom_we,
    input  logic [`BP_ROM_AW-1:0] rom_addr,
    input  logic [15:0]           rom_wdata,
    output logic [15:0]           pc,
    output logic [15:0]           inst,
    output logic [15:0]           redirect_pc,
    output logic                  taken,
    output logic                  mispredict,
    output logic [3:0]            br_rs         // register read for BR
);

    logic [15:0] predict_pc;
    logic        pred_taken;
    logic        id_is_b;
    logic        id_is_br;
    logic        id_pred;

    inst_rom u_rom (
        .clk       (clk),
        .rom_we    (rom_we),
        .rom_addr  (rom_addr),
        .rom_wdata (rom_wdata),
        .pc        (pc),
        .inst      (inst)
    );

    branch_predict_fsm u_pred (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .pc         (pc),
        .inst       (inst),
        .id_is_b    (id_is_b),
        .id_is_br   (id_is_br),
        .id_pred    (id_pred),
        .taken      (taken),
        .predict_pc (predict_pc),
        .pred_taken (pred_taken),
        .mispredict (mispredict)
    );

    branch_resolve u_resolve (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .mispredict  (mispredict),
        .pc          (pc),
        .inst        (inst),
        .pred_taken  (pred_taken),
        .flags       (flags),
        .br_data     (br_data),
        .id_is_b     (id_is_b),
        .id_is_br    (id_is_br),
        .id_pred     (id_pred),
        .taken       (taken),
        .br_rs       (br_rs),
        .redirect_pc (redirect_pc)
    );

    fetch_unit u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .mispredict  (mispredict),
        .predict_pc  (predict_pc),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

endmodule

//--- tests/bp_frontend_chk.sv
////////////////////////////////////////
// Front end checker
// Rebuilds the ROM image, IF/ID, the
// two-bit counter and the next pc from
// the top ports and asserts the DUT
// follows them
////////////////////////////////////////

`timescale 1ns/1ns
`include "bp_settings.svh"

module bp_frontend_chk (
    input logic        clk,
    input logic        rst_n,
    input logic        stall,
    input logic [2:0]  flags,          // {Z, V, N}
    input logic [15:0] br_data,
    input logic        rom_we,
    input logic [`BP_ROM_AW-1:0] rom_addr,
    input logic [15:0] rom_wdata,
    input logic [15:0] pc,
    input logic [15:0] inst,
    input logic [15:0] redirect_pc,
    input logic        taken,
    input logic        mispredict,
    input logic [3:0]  br_rs
);
    import bp_pkg::*;

    localparam logic [1:0] K_SEQ   = 2'd0;  // pc + 2
    localparam logic [1:0] K_PRED  = 2'd1;  // predicted B target
    localparam logic [1:0] K_REDIR = 2'd2;  // mispredict redirect
    localparam logic [1:0] K_HOLD  = 2'd3;  // stalled edge

    int          err_cnt = 0;   // read by the testbench
    logic [15:0] s_rom [0:2**`BP_ROM_AW-1];    // image seen on the load port
    logic [15:0] exp_inst;
    logic        after_rst;     // first cycle out of reset
    logic        kind_ok;
    logic [1:0]  kind;
    logic [15:0] exp_pc;
    logic        prev_mis;
    logic [1:0]  s_cnt;         // shadow counter
    logic [15:0] s_id_pc;       // shadow IF/ID
    logic [15:0] s_id_inst;
    logic        s_id_pred;
    logic        id_b;
    logic        id_br;
    logic        cond;
    logic        exp_taken;
    logic        exp_mis;
    logic [15:0] exp_redir;
    logic        f_pred;
    logic [15:0] f_target;

    // shadow of the program as it is loaded
    always_ff @(posedge clk) begin
        if (rom_we) begin
            s_rom[rom_addr] <= rom_wdata;
        end
    end

    // word at pc shifted right by one, wraps around the array
    assign exp_inst = s_rom[pc[`BP_ROM_AW:1]];

    assign id_b  = (s_id_inst[15:12] == b_op);
    assign id_br = (s_id_inst[15:12] == br_op);

    // condition table on Z V N
    always_comb begin
        case (s_id_inst[11:9])
            3'd0:    cond = ~flags[2];
            3'd1:    cond = flags[2];
            3'd2:    cond = ~flags[2] & ~flags[0];
            3'd3:    cond = flags[0];
            3'd4:    cond = flags[2] | ~flags[0];
            3'd5:    cond = flags[2] | flags[0];
            3'd6:    cond = flags[1];
            default: cond = 1'b1;
        endcase
    end

    assign exp_taken = (id_b | id_br) & cond;
    assign exp_mis   = id_b ? (s_id_pred != exp_taken) : (id_br & exp_taken);
    assign exp_redir = !exp_taken ? s_id_pc + 16'd2 :
                       id_br      ? br_data :
                       s_id_pc + 16'd2 + {{6{s_id_inst[8]}}, s_id_inst[8:0], 1'b0};

    // fetch side guess from the shadow counter
    assign f_pred   = (inst[15:12] == b_op) & s_cnt[1];
    assign f_target = pc + 16'd2 + {{6{inst[8]}}, inst[8:0], 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            after_rst <= 1'b1;
            kind_ok   <= 1'b0;
            kind      <= K_SEQ;
            exp_pc    <= 16'h0000;
            prev_mis  <= 1'b0;
            s_cnt     <= `BP_CNT_RESET;
            s_id_pc   <= 16'h0000;
            s_id_inst <= 16'h0000;      // nop
            s_id_pred <= 1'b0;
        end else begin
            after_rst <= 1'b0;
            kind_ok   <= 1'b1;
            prev_mis  <= mispredict;
            if (stall) begin
                kind   <= K_HOLD;
                exp_pc <= pc;           // everything frozen
            end else begin
                s_id_pc   <= pc;
                s_id_inst <= exp_mis ? 16'h0000 : inst;   // flushed slot
                s_id_pred <= exp_mis ? 1'b0 : f_pred;
                if (id_b && exp_taken && s_cnt != 2'd3) begin
                    s_cnt <= s_cnt + 2'd1;
                end else if (id_b && !exp_taken && s_cnt != 2'd0) begin
                    s_cnt <= s_cnt - 2'd1;
                end
                if (exp_mis) begin
                    kind   <= K_REDIR;
                    exp_pc <= exp_redir;
                end else if (f_pred) begin
                    kind   <= K_PRED;
                    exp_pc <= f_target;
                end else begin
                    kind   <= K_SEQ;
                    exp_pc <= pc + 16'd2;
                end
            end
        end
    end

    a_reset: assert property (@(posedge clk) disable iff (!rst_n)
        after_rst |-> (pc == 16'h0000 && !mispredict && !taken))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t pc/mispredict/taken exp 0000/0/0 got %h/%b/%b", $time,
                   $sampled(pc), $sampled(mispredict), $sampled(taken));
        end

    a_inst: assert property (@(posedge clk) disable iff (!rst_n) inst == exp_inst)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t inst exp %h got %h", $time, $sampled(exp_inst), $sampled(inst));
        end

    a_taken: assert property (@(posedge clk) disable iff (!rst_n) taken == exp_taken)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t taken exp %b got %b", $time, $sampled(exp_taken), $sampled(taken));
        end

    a_mis: assert property (@(posedge clk) disable iff (!rst_n) mispredict == exp_mis)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t mispredict exp %b got %b", $time,
                   $sampled(exp_mis), $sampled(mispredict));
        end

    a_redir: assert property (@(posedge clk) disable iff (!rst_n)
        (id_b | id_br) |-> redirect_pc == exp_redir)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t redirect_pc exp %h got %h", $time,
                   $sampled(exp_redir), $sampled(redirect_pc));
        end

    a_br_rs: assert property (@(posedge clk) disable iff (!rst_n)
        id_br |-> br_rs == s_id_inst[8:5])
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t br_rs exp %h got %h", $time, $sampled(s_id_inst[8:5]),
                   $sampled(br_rs));
        end

    // kind tells which next pc rule applied
    a_next_pc: assert property (@(posedge clk) disable iff (!rst_n) kind_ok |-> pc == exp_pc)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t pc exp %h got %h, rule %0d", $time, $sampled(exp_pc),
                   $sampled(pc), $sampled(kind));
        end

    a_hold_mis: assert property (@(posedge clk) disable iff (!rst_n)
        (kind_ok && kind == K_HOLD) |-> mispredict == prev_mis)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t mispredict during stall exp %b got %b", $time,
                   $sampled(prev_mis), $sampled(mispredict));
        end

endmodule

bind bp_frontend bp_frontend_chk chk_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .flags       (flags),
    .br_data     (br_data),
    .rom_we      (rom_we),
    .rom_addr    (rom_addr),
    .rom_wdata   (rom_wdata),
    .pc          (pc),
    .inst        (inst),
    .redirect_pc (redirect_pc),
    .taken       (taken),
    .mispredict  (mispredict),
    .br_rs       (br_rs)
);

//--- tests/bp_frontend_tb.sv
////////////////////////////////////////
// Front end testbench
// Loads a program per test in reset and
// runs it with random flags, BR values
// and stall gaps, the bound checker
// holds the assertions
////////////////////////////////////////

`timescale 1ns/1ns
`include "bp_settings.svh"

module bp_frontend_tb;

    localparam int CLK_NS    = 10;
    localparam int ROM_WORDS = 2 ** `BP_ROM_AW;
    localparam int N_TESTS   = 5;
    localparam int RST_CYC   = 3;
    localparam int RUN_STEPS = 30 + 70 + 150 + 100 + 150;    // run lengths of all tests
    // 40 cycles per run step, plus load and reset of every test
    localparam longint LIMIT_NS =
        longint'(40 * RUN_STEPS + N_TESTS * (ROM_WORDS + RST_CYC + 4)) * CLK_NS;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  stall;
    logic [2:0]            flags;       // {Z, V, N}
    logic [15:0]           br_data;
    logic                  rom_we;
    logic [`BP_ROM_AW-1:0] rom_addr;
    logic [15:0]           rom_wdata;
    logic [15:0]           pc;
    logic [15:0]           inst;
    logic [15:0]           redirect_pc;
    logic                  taken;
    logic                  mispredict;
    logic [3:0]            br_rs;
    logic [15:0]           prog [0:ROM_WORDS-1];   // image for the next load
    logic [31:0]           rng = 32'hde3b;
    int                    stall_left;
    int                    test_no;
    int                    errs_before;

    always #(CLK_NS / 2) clk = ~clk;

    bp_frontend bp_frontend_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flags       (flags),
        .br_data     (br_data),
        .rom_we      (rom_we),
        .rom_addr    (rom_addr),
        .rom_wdata   (rom_wdata),
        .pc          (pc),
        .inst        (inst),
        .redirect_pc (redirect_pc),
        .taken       (taken),
        .mispredict  (mispredict),
        .br_rs       (br_rs)
    );

    function automatic logic [31:0] next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // neither B nor BR, low byte is the word address
    function automatic logic [15:0] filler_word(input int addr);
        logic [31:0] r;
        logic [3:0]  op;
        r  = next_rand();
        op = r[3:0];
        if (op[3:1] == 3'b110) begin
            op[2] = 1'b0;
        end
        return {op, r[7:4], addr[7:0]};
    endfunction

    // 0 filler, 1 training loop, 2 B and BR mix, 3 BR heavy
    task automatic build_program(input int kind);
        logic [31:0] r;
        for (int a = 0; a < ROM_WORDS; a++) begin
            r = next_rand();
            prog[a] = filler_word(a);
            if (kind == 2 && a % 4 == 3) begin
                prog[a] = {4'b1100, r[2:0], r[12:4]};           // random cond and offset
            end else if ((kind == 2 && a % 7 == 5) || (kind == 3 && a % 3 == 2)) begin
                prog[a] = {4'b1101, r[2:0], r[16:13], r[21:17]};
            end
        end
        if (kind == 1) begin
            prog[6] = {4'b1100, 3'b001, 9'h1fb};    // B eq back to pc 4
            prog[7] = {4'b1101, 3'b111, 4'd3, 5'd0};  // BR always, br_data holds 4
        end
    endtask

    task automatic reset_and_load(input int kind);
        @(posedge clk);
        rst_n <= 1'b0;
        stall <= 1'b0;
        stall_left = 0;
        build_program(kind);
        for (int a = 0; a < ROM_WORDS; a++) begin
            @(posedge clk);
            rom_we    <= 1'b1;
            rom_addr  <= `BP_ROM_AW'(a);
            rom_wdata <= prog[a];
        end
        @(posedge clk);
        rom_we <= 1'b0;
        repeat (RST_CYC) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    // flags and br_data only move when the cycle just ended was unstalled
    task automatic run_steps(input int n, input bit use_stall,
                             input logic [2:0] fmask, input logic [2:0] fset,
                             input logic [15:0] bmask, input logic [15:0] bset);
        logic [31:0] r;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            r = next_rand();
            if (!stall) begin
                flags   <= (r[2:0] & fmask) | fset;
                br_data <= (r[31:16] & bmask) | bset;
            end
            if (stall_left > 0) begin
                stall <= 1'b1;
                stall_left--;
            end else if (use_stall && r[7:5] == 3'd0) begin
                stall <= 1'b1;
                stall_left = int'(r[9:8]);    // gap of 1 to 4 cycles
            end else begin
                stall <= 1'b0;
            end
        end
    endtask

    task automatic finish_test(input string name);
        int now_errs;
        repeat (2) @(posedge clk);      // let the last cycle be checked
        now_errs = bp_frontend_inst.chk_inst.err_cnt;
        test_no++;
        $display("test %0d %s finished, %0d errors", test_no, name, now_errs - errs_before);
        errs_before = now_errs;
    endtask

    initial begin
        rst_n       = 1'b0;
        stall       = 1'b0;
        flags       = 3'b000;
        br_data     = 16'h0000;
        rom_we      = 1'b0;
        rom_addr    = '0;
        rom_wdata   = 16'h0000;
        stall_left  = 0;
        test_no     = 0;
        errs_before = 0;

        reset_and_load(0);      // straight line fetch
        run_steps(30, 1'b0, 3'b111, 3'b000, 16'hfffe, 16'h0000);
        finish_test("reset_and_step");

        reset_and_load(1);      // Z set trains taken, Z clear walks it back
        run_steps(40, 1'b0, 3'b011, 3'b100, 16'h0000, 16'h0004);
        run_steps(30, 1'b0, 3'b011, 3'b000, 16'h0000, 16'h0004);
        finish_test("counter_training");

        reset_and_load(2);
        run_steps(150, 1'b0, 3'b111, 3'b000, 16'hfffe, 16'h0000);
        finish_test("b_redirect");

        reset_and_load(3);
        run_steps(100, 1'b0, 3'b111, 3'b000, 16'hfffe, 16'h0000);
        finish_test("br_redirect");

        reset_and_load(2);
        run_steps(150, 1'b1, 3'b111, 3'b000, 16'hfffe, 16'h0000);
        finish_test("stall_hold");

        $display("%0d tests run, %0d errors", test_no, bp_frontend_inst.chk_inst.err_cnt);
        if (bp_frontend_inst.chk_inst.err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(LIMIT_NS);
        $display("watchdog timeout after %0d ns, tests did not complete", LIMIT_NS);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- files.f
+incdir+rtl
rtl/bp_pkg.sv
rtl/inst_rom.sv
rtl/branch_predict_fsm.sv
rtl/branch_resolve.sv
rtl/fetch_unit.sv
rtl/bp_frontend.sv
tests/bp_frontend_chk.sv
tests/bp_frontend_tb.sv

//--- run.sh
#!/bin/sh
# build the front end testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module bp_frontend_tb \
        -f files.f -o bp_frontend_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/bp_frontend_sim +verilator+error+limit+1000 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
